// ==== logic/rv32_isa_pkg.sv ====
package rv32_isa_pkg;

    // Data path and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]           instr_t;

    // Major opcodes kept in this core
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

    // funct3 values for the integer ALU group
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Selects SUB over ADD and SRA over SRL
    localparam int F7_ALT_BIT = 30;

endpackage

// ==== logic/core_ctrl_pkg.sv ====
package core_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_t;

    // Operand B source
    typedef enum logic {
        SRC_B_RS2 = 1'b0,
        SRC_B_IMM = 1'b1
    } src_b_sel_t;

    // LUI takes its writeback value from the immediate
    typedef enum logic {
        WB_SEL_ALU = 1'b0,
        WB_SEL_IMM = 1'b1
    } wb_sel_t;

    // Operand forwarding select
    localparam logic FWD_NONE = 1'b0;
    localparam logic FWD_WB   = 1'b1;

endpackage

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  rv32_isa_pkg::xlen_t    a,
    input  rv32_isa_pkg::xlen_t    b,
    input  core_ctrl_pkg::alu_op_t op,
    output rv32_isa_pkg::xlen_t    result
);
    import rv32_isa_pkg::*;
    import core_ctrl_pkg::*;

    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = xlen_t'($signed(a) < $signed(b));
            ALU_SLTU:   result = xlen_t'(a < b);
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = xlen_t'($signed(a) >>> shamt);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                    clk,
    input  logic                    rst,
    input  rv32_isa_pkg::reg_addr_t rs1_addr,
    input  rv32_isa_pkg::reg_addr_t rs2_addr,
    output rv32_isa_pkg::xlen_t     rs1_data,
    output rv32_isa_pkg::xlen_t     rs2_data,
    input  logic                    wb_we,
    input  rv32_isa_pkg::reg_addr_t wb_rd,
    input  rv32_isa_pkg::xlen_t     wb_data
);
    import rv32_isa_pkg::*;

    xlen_t regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Write-through so decode sees the result retiring this cycle
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else if (wb_we && wb_rd == rs1_addr) begin
            rs1_data = wb_data;
        end else begin
            rs1_data = regs[rs1_addr];
        end
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else if (wb_we && wb_rd == rs2_addr) begin
            rs2_data = wb_data;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

    // The writer leaves each reset cycle with its write enable low
    assert property (@(posedge clk) rst |=> !wb_we)
        else $error("write presented to the register file during reset");

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      instr_valid,
    input  rv32_isa_pkg::instr_t      instr,
    output logic                      id_valid,
    output rv32_isa_pkg::reg_addr_t   rs1_addr,
    output rv32_isa_pkg::reg_addr_t   rs2_addr,
    output rv32_isa_pkg::reg_addr_t   id_rs1_addr,
    output rv32_isa_pkg::reg_addr_t   id_rs2_addr,
    output rv32_isa_pkg::reg_addr_t   id_rd,
    output rv32_isa_pkg::xlen_t       id_imm,
    output core_ctrl_pkg::alu_op_t    id_alu_op,
    output core_ctrl_pkg::src_b_sel_t id_src_b_sel,
    output core_ctrl_pkg::wb_sel_t    id_wb_sel,
    output logic                      id_reg_write,
    output logic                      id_illegal
);
    import rv32_isa_pkg::*;
    import core_ctrl_pkg::*;

    instr_t      instr_q;
    logic        valid_q;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        alt_bit;
    reg_addr_t   rs1_field;
    reg_addr_t   rs2_field;
    xlen_t       i_imm;
    xlen_t       u_imm;
    logic        legal;
    logic        reg_write;

    function automatic alu_op_t map_alu_op(
        input logic [2:0] f3,
        input logic       alt,
        input logic       is_reg
    );
        alu_op_t op;
        case (f3)
            F3_ADD_SUB: op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    // Instruction input register
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= instr_valid;
        end
        if (instr_valid) begin
            instr_q <= instr;
        end
    end

    assign opcode    = instr_q[6:0];
    assign funct3    = instr_q[14:12];
    // Same bit is imm[10] for the immediate shifts
    assign alt_bit   = instr_q[F7_ALT_BIT];
    assign rs1_field = instr_q[19:15];
    assign rs2_field = instr_q[24:20];

    assign i_imm = {{(XLEN-12){instr_q[31]}}, instr_q[31:20]};
    assign u_imm = {instr_q[31:12], 12'b0};

    always_comb begin
        legal        = 1'b0;
        reg_write    = 1'b0;
        id_alu_op    = ALU_ADD;
        id_src_b_sel = SRC_B_RS2;
        id_wb_sel    = WB_SEL_ALU;
        case (opcode)
            OPCODE_OP: begin
                legal     = 1'b1;
                reg_write = 1'b1;
                id_alu_op = map_alu_op(funct3, alt_bit, 1'b1);
            end
            OPCODE_OP_IMM: begin
                legal        = 1'b1;
                reg_write    = 1'b1;
                id_alu_op    = map_alu_op(funct3, alt_bit, 1'b0);
                id_src_b_sel = SRC_B_IMM;
            end
            OPCODE_LUI: begin
                legal        = 1'b1;
                reg_write    = 1'b1;
                id_alu_op    = ALU_PASS_B;
                id_src_b_sel = SRC_B_IMM;
                id_wb_sel    = WB_SEL_IMM;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    assign id_valid = valid_q;
    assign rs1_addr = rs1_field;
    assign rs2_addr = rs2_field;
    assign id_rd    = instr_q[11:7];
    assign id_imm   = (opcode == OPCODE_LUI) ? u_imm : i_imm;

    // Keep immediate bits in unused source fields out of forwarding
    assign id_rs1_addr = (opcode == OPCODE_LUI) ? '0 : rs1_field;
    assign id_rs2_addr = (opcode == OPCODE_OP) ? rs2_field : '0;

    assign id_reg_write = valid_q && reg_write;
    assign id_illegal   = valid_q && !legal;

    assert property (@(posedge clk) disable iff (rst) !(id_illegal && id_reg_write))
        else $error("decode flags an instruction as illegal and writing");

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      id_valid,
    input  rv32_isa_pkg::reg_addr_t   id_rs1_addr,
    input  rv32_isa_pkg::reg_addr_t   id_rs2_addr,
    input  rv32_isa_pkg::reg_addr_t   id_rd,
    input  rv32_isa_pkg::xlen_t       id_imm,
    input  core_ctrl_pkg::alu_op_t    id_alu_op,
    input  core_ctrl_pkg::src_b_sel_t id_src_b_sel,
    input  core_ctrl_pkg::wb_sel_t    id_wb_sel,
    input  logic                      id_reg_write,
    input  logic                      id_illegal,
    input  rv32_isa_pkg::xlen_t       rs1_data,
    input  rv32_isa_pkg::xlen_t       rs2_data,
    output logic                      wb_we,
    output rv32_isa_pkg::reg_addr_t   wb_rd,
    output rv32_isa_pkg::xlen_t       wb_data,
    output logic                      retire_valid,
    output rv32_isa_pkg::reg_addr_t   retire_rd,
    output rv32_isa_pkg::xlen_t       retire_data,
    output logic                      retire_illegal
);
    import rv32_isa_pkg::*;
    import core_ctrl_pkg::*;

    // Decode to execute register
    logic       ex_valid;
    logic       ex_reg_write;
    logic       ex_illegal;
    reg_addr_t  ex_rs1_addr;
    reg_addr_t  ex_rs2_addr;
    reg_addr_t  ex_rd;
    xlen_t      ex_imm;
    alu_op_t    ex_alu_op;
    src_b_sel_t ex_src_b_sel;
    wb_sel_t    ex_wb_sel;
    xlen_t      ex_rs1_data;
    xlen_t      ex_rs2_data;

    // Execute to writeback register
    logic       wb_valid_q;
    logic       wb_we_q;
    logic       wb_illegal_q;
    reg_addr_t  wb_rd_q;
    xlen_t      wb_data_q;

    logic       fwd_a_sel;
    logic       fwd_b_sel;
    xlen_t      op_a;
    xlen_t      rs2_val;
    xlen_t      op_b;
    xlen_t      alu_result;
    xlen_t      ex_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid     <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_illegal   <= 1'b0;
        end else begin
            ex_valid     <= id_valid;
            ex_reg_write <= id_reg_write;
            ex_illegal   <= id_illegal;
        end
        ex_rs1_addr  <= id_rs1_addr;
        ex_rs2_addr  <= id_rs2_addr;
        ex_rd        <= id_rd;
        ex_imm       <= id_imm;
        ex_alu_op    <= id_alu_op;
        ex_src_b_sel <= id_src_b_sel;
        ex_wb_sel    <= id_wb_sel;
        ex_rs1_data  <= rs1_data;
        ex_rs2_data  <= rs2_data;
    end

    // Older results already reached decode through the register file
    assign fwd_a_sel = (wb_we_q && ex_rs1_addr != '0 && ex_rs1_addr == wb_rd_q) ?
                       FWD_WB : FWD_NONE;
    assign fwd_b_sel = (wb_we_q && ex_rs2_addr != '0 && ex_rs2_addr == wb_rd_q) ?
                       FWD_WB : FWD_NONE;

    assign op_a    = (fwd_a_sel == FWD_WB) ? wb_data_q : ex_rs1_data;
    assign rs2_val = (fwd_b_sel == FWD_WB) ? wb_data_q : ex_rs2_data;
    assign op_b    = (ex_src_b_sel == SRC_B_IMM) ? ex_imm : rs2_val;

    alu alu_inst (
        .a      (op_a),
        .b      (op_b),
        .op     (ex_alu_op),
        .result (alu_result)
    );

    assign ex_result = (ex_wb_sel == WB_SEL_IMM) ? ex_imm : alu_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_q   <= 1'b0;
            wb_we_q      <= 1'b0;
            wb_illegal_q <= 1'b0;
            wb_rd_q      <= '0;
            wb_data_q    <= '0;
        end else begin
            wb_valid_q   <= ex_valid;
            wb_we_q      <= ex_reg_write;
            wb_illegal_q <= ex_illegal;
            wb_rd_q      <= ex_rd;
            wb_data_q    <= ex_result;
        end
    end

    assign wb_we   = wb_we_q;
    assign wb_rd   = wb_rd_q;
    assign wb_data = wb_data_q;

    assign retire_valid   = wb_valid_q;
    assign retire_rd      = wb_rd_q;
    assign retire_data    = wb_data_q;
    assign retire_illegal = wb_illegal_q;

    // An illegal word from decode retires two cycles later without a write
    assert property (@(posedge clk) disable iff (rst)
        id_illegal |=> ##1 (retire_valid && retire_illegal && !wb_we))
        else $error("illegal instruction did not retire cleanly");

endmodule

// ==== logic/rv32i_alu_pipe.sv ====
`timescale 1ns/1ps

module rv32i_alu_pipe (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  rv32_isa_pkg::instr_t    instr,
    output logic                    retire_valid,
    output rv32_isa_pkg::reg_addr_t retire_rd,
    output rv32_isa_pkg::xlen_t     retire_data,
    output logic                    retire_illegal
);
    import rv32_isa_pkg::*;
    import core_ctrl_pkg::*;

    // Decode outputs
    logic       id_valid;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    reg_addr_t  id_rs1_addr;
    reg_addr_t  id_rs2_addr;
    reg_addr_t  id_rd;
    xlen_t      id_imm;
    alu_op_t    id_alu_op;
    src_b_sel_t id_src_b_sel;
    wb_sel_t    id_wb_sel;
    logic       id_reg_write;
    logic       id_illegal;

    // Register file read and write ports
    xlen_t      rs1_data;
    xlen_t      rs2_data;
    logic       wb_we;
    reg_addr_t  wb_rd;
    xlen_t      wb_data;

    decode_stage decode_stage_inst (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .id_valid     (id_valid),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .id_rs1_addr  (id_rs1_addr),
        .id_rs2_addr  (id_rs2_addr),
        .id_rd        (id_rd),
        .id_imm       (id_imm),
        .id_alu_op    (id_alu_op),
        .id_src_b_sel (id_src_b_sel),
        .id_wb_sel    (id_wb_sel),
        .id_reg_write (id_reg_write),
        .id_illegal   (id_illegal)
    );

    register_file register_file_inst (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    execute_stage execute_stage_inst (
        .clk            (clk),
        .rst            (rst),
        .id_valid       (id_valid),
        .id_rs1_addr    (id_rs1_addr),
        .id_rs2_addr    (id_rs2_addr),
        .id_rd          (id_rd),
        .id_imm         (id_imm),
        .id_alu_op      (id_alu_op),
        .id_src_b_sel   (id_src_b_sel),
        .id_wb_sel      (id_wb_sel),
        .id_reg_write   (id_reg_write),
        .id_illegal     (id_illegal),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .wb_we          (wb_we),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .retire_illegal (retire_illegal)
    );

endmodule

// ==== tests/rv32i_alu_pipe_tb.sv ====
`timescale 1ns/1ps

module rv32i_alu_pipe_tb;
    import rv32_isa_pkg::*;

    localparam int NUM_FIXED  = 25;
    localparam int NUM_RANDOM = 48;
    localparam int NUM_TESTS  = NUM_FIXED + NUM_RANDOM;
    localparam int LATENCY    = 3;
    localparam int WAIT_LIMIT = 40;

    typedef struct packed {
        instr_t    instr;
        reg_addr_t rd;
        xlen_t     data;
        logic      illegal;
    } entry_t;

    logic      clk;
    logic      rst;
    logic      instr_valid;
    instr_t    instr;
    logic      retire_valid;
    reg_addr_t retire_rd;
    xlen_t     retire_data;
    logic      retire_illegal;

    entry_t    test_table [NUM_TESTS];
    xlen_t     ref_regs [32];
    int        n_entries;
    integer    seed = 697;
    int        cycle_cnt = 0;
    int        issue_cycle [$];
    int        pass_cnt = 0;
    int        fail_cnt = 0;
    logic      timed_out = 1'b0;
    logic      monitor_done = 1'b0;

    rv32i_alu_pipe rv32i_alu_pipe_inst (
        .clk            (clk),
        .rst            (rst),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .retire_illegal (retire_illegal)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Cycle in which each instruction is presented at the input
    always @(negedge clk) begin
        if (rst === 1'b0 && instr_valid === 1'b1) begin
            issue_cycle.push_back(cycle_cnt);
        end
    end

    function automatic instr_t rtype(input logic alt, input int rs2, input int rs1,
                                     input logic [2:0] f3, input int rd);
        return {1'b0, alt, 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], OPCODE_OP};
    endfunction

    function automatic instr_t itype(input logic [11:0] imm, input int rs1,
                                     input logic [2:0] f3, input int rd);
        return {imm, rs1[4:0], f3, rd[4:0], OPCODE_OP_IMM};
    endfunction

    function automatic instr_t lui_word(input logic [19:0] imm, input int rd);
        return {imm, rd[4:0], OPCODE_LUI};
    endfunction

    // ISA reference for one instruction against the model registers
    function automatic void model_step(input instr_t w, output xlen_t res, output logic bad);
        xlen_t      a;
        xlen_t      b;
        xlen_t      imm;
        logic [4:0] sh;
        a   = ref_regs[w[19:15]];
        imm = {{20{w[31]}}, w[31:20]};
        b   = (w[6:0] == OPCODE_OP) ? ref_regs[w[24:20]] : imm;
        sh  = b[4:0];
        bad = 1'b0;
        res = '0;
        if (w[6:0] == OPCODE_LUI) begin
            res = {w[31:12], 12'b0};
        end else if (w[6:0] == OPCODE_OP || w[6:0] == OPCODE_OP_IMM) begin
            case (w[14:12])
                3'd0: res = (w[6:0] == OPCODE_OP && w[30]) ? a - b : a + b;
                3'd1: res = a << sh;
                3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: res = (a < b) ? 32'd1 : 32'd0;
                3'd4: res = a ^ b;
                3'd5: begin
                    if (w[30]) begin
                        res = $signed(a) >>> sh;
                    end else begin
                        res = a >> sh;
                    end
                end
                3'd6: res = a | b;
                default: res = a & b;
            endcase
        end else begin
            bad = 1'b1;
        end
    endfunction

    // Small register range so random entries depend on each other often
    function automatic instr_t random_instr();
        int          kind;
        int          rd;
        int          rs1;
        int          rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        kind = $unsigned($random(seed)) % 8;
        rd   = $unsigned($random(seed)) % 8;
        rs1  = $unsigned($random(seed)) % 8;
        rs2  = $unsigned($random(seed)) % 8;
        f3   = $random(seed);
        imm  = $random(seed);
        alt  = $random(seed);
        if (kind == 0) begin
            return lui_word(20'($random(seed)), rd);
        end else if (kind < 4) begin
            return rtype((f3 == 3'd0 || f3 == 3'd5) ? alt : 1'b0, rs2, rs1, f3, rd);
        end
        if (f3 == 3'd1) begin
            imm = {7'b0, imm[4:0]};
        end else if (f3 == 3'd5) begin
            imm = {1'b0, alt, 5'b0, imm[4:0]};
        end
        return itype(imm, rs1, f3, rd);
    endfunction

    task automatic add_entry(input instr_t w, input xlen_t data, input logic bad);
        test_table[n_entries] = '{w, w[11:7], data, bad};
        if (!bad && w[11:7] != 5'd0) begin
            ref_regs[w[11:7]] = data;
        end
        n_entries++;
    endtask

    task automatic build_table();
        instr_t w;
        xlen_t  res;
        logic   bad;
        n_entries = 0;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        add_entry(itype(12'd100, 0, F3_ADD_SUB, 1), 32'h0000_0064, 1'b0);
        add_entry(itype(12'hff9, 0, F3_ADD_SUB, 2), 32'hffff_fff9, 1'b0);
        // One and two positions after their producers
        add_entry(rtype(1'b0, 2, 1, F3_ADD_SUB, 3), 32'h0000_005d, 1'b0);
        add_entry(rtype(1'b1, 2, 1, F3_ADD_SUB, 4), 32'h0000_006b, 1'b0);
        add_entry(rtype(1'b0, 2, 1, F3_SLL, 5), 32'hc800_0000, 1'b0);
        add_entry(rtype(1'b0, 1, 2, F3_SLT, 6), 32'h0000_0001, 1'b0);
        add_entry(rtype(1'b0, 1, 2, F3_SLTU, 7), 32'h0000_0000, 1'b0);
        add_entry(rtype(1'b0, 2, 1, F3_XOR, 8), 32'hffff_ff9d, 1'b0);
        add_entry(rtype(1'b0, 1, 2, F3_SRL_SRA, 9), 32'h0fff_ffff, 1'b0);
        add_entry(rtype(1'b1, 1, 2, F3_SRL_SRA, 10), 32'hffff_ffff, 1'b0);
        add_entry(rtype(1'b0, 2, 1, F3_OR, 11), 32'hffff_fffd, 1'b0);
        add_entry(rtype(1'b0, 2, 1, F3_AND, 12), 32'h0000_0060, 1'b0);
        add_entry(itype(12'hffb, 2, F3_SLT, 13), 32'h0000_0001, 1'b0);
        add_entry(itype(12'hfff, 1, F3_SLTU, 14), 32'h0000_0001, 1'b0);
        add_entry(itype(12'h0ff, 1, F3_XOR, 15), 32'h0000_009b, 1'b0);
        add_entry(itype(12'h003, 1, F3_OR, 16), 32'h0000_0067, 1'b0);
        add_entry(itype(12'h0f0, 2, F3_AND, 17), 32'h0000_00f0, 1'b0);
        add_entry(itype(12'h004, 1, F3_SLL, 18), 32'h0000_0640, 1'b0);
        add_entry(itype(12'h01c, 2, F3_SRL_SRA, 19), 32'h0000_000f, 1'b0);
        add_entry(itype(12'h401, 2, F3_SRL_SRA, 20), 32'hffff_fffc, 1'b0);
        add_entry(lui_word(20'habcde, 21), 32'habcd_e000, 1'b0);
        // x0 write followed directly by an x0 read
        add_entry(itype(12'd5, 1, F3_ADD_SUB, 0), 32'h0000_0069, 1'b0);
        add_entry(rtype(1'b0, 0, 0, F3_ADD_SUB, 22), 32'h0000_0000, 1'b0);
        // Unknown opcode aimed at x1 must leave x1 unchanged
        add_entry(32'h0000_00ff, 32'h0000_0000, 1'b1);
        add_entry(itype(12'd0, 1, F3_ADD_SUB, 23), 32'h0000_0064, 1'b0);
        for (int k = 0; k < NUM_RANDOM; k++) begin
            w = random_instr();
            model_step(w, res, bad);
            add_entry(w, res, bad);
        end
    endtask

    // Stimulus
    initial begin
        int   gap;
        int   waited;
        logic idle_ok;
        clk         = 1'b0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        idle_ok     = 1'b1;
        build_table();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (5) begin
            @(negedge clk);
            assert (retire_valid === 1'b0 && retire_illegal === 1'b0 && retire_data === '0)
                else begin
                    $display("FAIL %0t: retire port active before any instruction", $time);
                    idle_ok = 1'b0;
                end
        end
        if (idle_ok) begin
            pass_cnt++;
            $display("Test reset idle passed");
        end else begin
            fail_cnt++;
            $display("Test reset idle failed");
        end
        for (int i = 0; i < NUM_TESTS; i++) begin
            gap = 0;
            if (i >= NUM_FIXED && ($random(seed) & 3) == 0) begin
                gap = 1 + $unsigned($random(seed)) % 2;
            end
            repeat (gap) begin
                @(posedge clk);
                instr_valid <= 1'b0;
            end
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= test_table[i].instr;
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        waited = 0;
        while (!monitor_done && waited < NUM_TESTS * WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!monitor_done) begin
            $display("Retire checker never finished");
            timed_out = 1'b1;
        end
        $display("Tests run %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt,
                 fail_cnt);
        if (fail_cnt == 0 && !timed_out && pass_cnt == NUM_TESTS + 2) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Retire checker takes one table entry per retire in input order
    initial begin
        int     waited;
        int     errs;
        int     issued;
        entry_t exp;
        for (int i = 0; i < NUM_TESTS; i++) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (retire_valid !== 1'b1 && waited < WAIT_LIMIT);
            if (retire_valid !== 1'b1) begin
                $display("Retire for test %0d never arrived", i);
                timed_out = 1'b1;
                break;
            end
            errs   = 0;
            exp    = test_table[i];
            issued = -1;
            assert (issue_cycle.size() > 0) else begin
                $display("Test %0d retired with no instruction outstanding", i);
                errs++;
            end
            if (issue_cycle.size() > 0) begin
                issued = issue_cycle.pop_front();
            end
            assert (cycle_cnt - issued == LATENCY) else begin
                $display("FAIL %0t: test %0d retired after %0d cycles", $time, i,
                         cycle_cnt - issued);
                errs++;
            end
            assert (retire_illegal === exp.illegal) else begin
                $display("FAIL %0t: test %0d illegal flag %b, expected %b", $time, i,
                         retire_illegal, exp.illegal);
                errs++;
            end
            if (!exp.illegal) begin
                assert (retire_rd === exp.rd && retire_data === exp.data) else begin
                    $display("FAIL %0t: test %0d got x%0d = %h, expected x%0d = %h", $time,
                             i, retire_rd, retire_data, exp.rd, exp.data);
                    errs++;
                end
            end
            if (errs == 0) begin
                pass_cnt++;
                $display("Test %0d passed, x%0d = %h", i, retire_rd, retire_data);
            end else begin
                fail_cnt++;
                $display("Test %0d failed", i);
            end
        end
        if (!timed_out) begin
            errs = 0;
            repeat (6) begin
                @(negedge clk);
                assert (retire_valid === 1'b0) else begin
                    $display("FAIL %0t: extra retire after the last instruction", $time);
                    errs++;
                end
            end
            if (errs == 0) begin
                pass_cnt++;
                $display("Test no extra retires passed");
            end else begin
                fail_cnt++;
                $display("Test no extra retires failed");
            end
        end
        monitor_done = 1'b1;
    end

endmodule

// ==== rv32i_alu_pipe.f ====
logic/rv32_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/rv32i_alu_pipe.sv
tests/rv32i_alu_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: rv32i_alu_pipe

sources:
  - logic/rv32_isa_pkg.sv
  - logic/core_ctrl_pkg.sv
  - logic/alu.sv
  - logic/register_file.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/rv32i_alu_pipe.sv
  - target: test
    files:
      - tests/rv32i_alu_pipe_tb.sv
